// File: sim.f
+incdir+src
src/lsu_pkg.sv
src/decouple_if.sv
src/axi_if.sv
src/lsu.sv
src/axi_sram.sv
src/lsu_top.sv
dv/tb_lsu_top.sv

// File: Bender.yml
package:
  name: lsu_subsystem

export_include_dirs:
  - src

sources:
  - files:
      - src/lsu_pkg.sv
      - src/decouple_if.sv
      - src/axi_if.sv
      - src/lsu.sv
      - src/axi_sram.sv
      - src/lsu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_lsu_top.sv

// File: dv/tb_lsu_top.sv
`timescale 1ns/1ps

`include "lsu_params.svh"

module tb_lsu_top;

  import lsu_pkg::*;

  localparam int MEM_BYTES = `LSU_MEM_WORDS * 8;
  localparam int LIMIT     = 40;

  logic                   clk;
  logic                   rstn;
  logic [`LSU_ADDR_W-1:0] raddr;
  load_func_e             rfunc;
  logic                   rreq_valid;
  logic                   rreq_ready;
  logic [`LSU_DATA_W-1:0] rdata;
  logic                   rres_valid;
  logic                   rres_ready;
  logic [`LSU_ADDR_W-1:0] waddr;
  store_func_e            wfunc;
  logic [`LSU_DATA_W-1:0] wdata;
  logic                   wreq_valid;
  logic                   wreq_ready;
  logic                   wres_valid;
  logic                   wres_ready;

  // byte image of the sram, indexed modulo its size
  logic [7:0] model [MEM_BYTES];

  lsu_top dut_i (.*);

  always #50 clk = ~clk;

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  task automatic report_timeout(input string sig);
    $display("timeout at %0t: %s never went high", $time, sig);
    $display("test failed");
    $fatal(1, "no handshake on %s", sig);
  endtask

  function automatic int store_bytes(input logic [2:0] code);
    case (code)
      ST_H:    return 2;
      ST_W:    return 4;
      default: return 1;
    endcase
  endfunction

  function automatic int load_bytes(input logic [2:0] code);
    case (code)
      LD_BS, LD_BU: return 1;
      LD_HS, LD_HU: return 2;
      default:      return 4;
    endcase
  endfunction

  // formatting rule: low bytes from the model, then sign or zero extension
  function automatic logic [31:0] expect_load(input logic [31:0] addr, input logic [2:0] code);
    logic [31:0] raw;
    for (int i = 0; i < 4; i++) begin
      raw[8*i +: 8] = model[(addr + 32'(i)) % MEM_BYTES];
    end
    case (code)
      LD_BS:   return {{24{raw[7]}}, raw[7:0]};
      LD_BU:   return {24'h0, raw[7:0]};
      LD_HS:   return {{16{raw[15]}}, raw[15:0]};
      LD_HU:   return {16'h0, raw[15:0]};
      default: return raw;
    endcase
  endfunction

  // hold is the number of cycles the response is kept waiting
  task automatic load_check(input logic [31:0] addr, input logic [2:0] code, input int hold);
    int cnt;
    logic [31:0] held;
    @(posedge clk);
    raddr      <= addr;
    rfunc      <= load_func_e'(code);
    rreq_valid <= 1'b1;
    rres_ready <= (hold == 0);
    @(negedge clk);
    cnt = 0;
    while (!rreq_ready) begin
      if (cnt == LIMIT) begin
        report_timeout("rreq_ready");
      end
      @(negedge clk);
      cnt++;
    end
    check_val("rres_valid", rres_valid, 1'b0);
    @(posedge clk);
    rreq_valid <= 1'b0;
    // one cycle after the handshake
    @(negedge clk);
    check_val("rres_valid", rres_valid, 1'b1);
    held = rdata;
    check_val("rdata", held, expect_load(addr, code));
    for (int i = 0; i < hold; i++) begin
      check_val("rres_valid", rres_valid, 1'b1);
      check_val("rdata", rdata, held);
      check_val("rreq_ready", rreq_ready, 1'b0);
      @(posedge clk);
      if (i == hold - 1) begin
        rres_ready <= 1'b1;
      end
      @(negedge clk);
    end
    check_val("rres_valid", rres_valid, 1'b1);
    check_val("rdata", rdata, held);
    @(posedge clk);
    @(negedge clk);
    check_val("rres_valid", rres_valid, 1'b0);
    check_val("rreq_ready", rreq_ready, 1'b1);
  endtask

  task automatic store_data(input logic [31:0] addr, input logic [2:0] code,
                            input logic [31:0] data, input int hold);
    int cnt;
    @(posedge clk);
    waddr      <= addr;
    wfunc      <= store_func_e'(code);
    wdata      <= data;
    wreq_valid <= 1'b1;
    wres_ready <= (hold == 0);
    @(negedge clk);
    cnt = 0;
    while (!wreq_ready) begin
      if (cnt == LIMIT) begin
        report_timeout("wreq_ready");
      end
      @(negedge clk);
      cnt++;
    end
    check_val("wres_valid", wres_valid, 1'b0);
    @(posedge clk);
    wreq_valid <= 1'b0;
    for (int i = 0; i < store_bytes(code); i++) begin
      model[(addr + 32'(i)) % MEM_BYTES] = data[8*i +: 8];
    end
    @(negedge clk);
    check_val("wres_valid", wres_valid, 1'b1);
    for (int i = 0; i < hold; i++) begin
      check_val("wres_valid", wres_valid, 1'b1);
      check_val("wreq_ready", wreq_ready, 1'b0);
      @(posedge clk);
      if (i == hold - 1) begin
        wres_ready <= 1'b1;
      end
      @(negedge clk);
    end
    check_val("wres_valid", wres_valid, 1'b1);
    @(posedge clk);
    @(negedge clk);
    check_val("wres_valid", wres_valid, 1'b0);
  endtask

  task automatic word_roundtrip();
    store_data(32'h40, ST_W, 32'hdead_beef, 0);
    load_check(32'h40, LD_W, 0);
    // alias one memory size higher
    load_check(32'h40 + MEM_BYTES, LD_W, 0);
  endtask

  // pattern covers every address bit
  task automatic fill_memory();
    for (int a = 0; a < MEM_BYTES; a += 4) begin
      store_data(32'(a), ST_W, 32'(a) * 32'h9e37_79b1 + 32'h1357_9bdf, 0);
    end
  endtask

  task automatic byte_lanes();
    logic [7:0] bv;
    for (int off = 0; off < 8; off++) begin
      bv = 8'h1f + 8'(35 * off);
      store_data(32'h100 + off, ST_B, {24'hffffff, bv}, 0);
      load_check(32'h100 + off, LD_BS, 0);
      load_check(32'h100 + off, LD_BU, 0);
      load_check(32'h100, LD_W, 0);
      load_check(32'h104, LD_W, 0);
    end
  endtask

  task automatic halfword_lanes();
    logic [15:0] hv;
    for (int off = 0; off < 8; off += 2) begin
      hv = 16'h8000 | 16'(off * 16'h0123);
      store_data(32'h180 + off, ST_H, {16'haaaa, hv}, 0);
      load_check(32'h180 + off, LD_HS, 0);
      load_check(32'h180 + off, LD_HU, 0);
      hv = 16'h7000 | 16'(off * 16'h0123);
      store_data(32'h180 + off, ST_H, {16'h5555, hv}, 0);
      load_check(32'h180 + off, LD_HS, 0);
      load_check(32'h180 + off, LD_HU, 0);
    end
    store_data(32'h180, ST_W, 32'h8765_4321, 0);
    store_data(32'h184, ST_W, 32'h0fed_cba9, 0);
    load_check(32'h180, LD_W, 0);
    load_check(32'h184, LD_W, 0);
    load_check(32'h182, LD_HS, 0);
    load_check(32'h187, LD_BS, 0);
  endtask

  task automatic backpressure();
    logic [31:0] addr;
    for (int n = 0; n < 12; n++) begin
      addr = 32'h200 + 8 * n;
      store_data(addr, ST_W, $urandom, 1 + $urandom % 8);
      load_check(addr, LD_W, 1 + $urandom % 8);
      load_check(addr + 1, LD_HS, 1 + $urandom % 8);
    end
  endtask

  // raw 3-bit codes, so the unlisted ones are exercised too
  task automatic random_mix();
    logic [31:0] addr;
    logic [2:0]  code;
    int          size;
    for (int n = 0; n < 200; n++) begin
      code = 3'($urandom);
      addr = $urandom;
      if ($urandom % 2) begin
        size = store_bytes(code);
        addr[2:0] = 3'($urandom % (9 - size));
        store_data(addr, code, $urandom, 0);
      end else begin
        size = load_bytes(code);
        addr[2:0] = 3'($urandom % (9 - size));
        load_check(addr, code, 0);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h95af4cb9));
    clk        = 1'b0;
    rstn       = 1'b0;
    raddr      = '0;
    rfunc      = LD_W;
    rreq_valid = 1'b0;
    rres_ready = 1'b1;
    waddr      = '0;
    wfunc      = ST_W;
    wdata      = '0;
    wreq_valid = 1'b0;
    wres_ready = 1'b1;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    // readies held off for one cycle after reset
    @(negedge clk);
    check_val("rres_valid", rres_valid, 1'b0);
    check_val("wres_valid", wres_valid, 1'b0);
    check_val("rreq_ready", rreq_ready, 1'b0);
    check_val("wreq_ready", wreq_ready, 1'b0);
    word_roundtrip();
    fill_memory();
    byte_lanes();
    halfword_lanes();
    backpressure();
    random_mix();
    $display("test passed");
    $finish;
  end

endmodule

// File: src/lsu_top.sv
`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_top (
  input  logic                     clk,
  input  logic                     rstn,

  input  logic [`LSU_ADDR_W-1:0]   raddr,
  input  lsu_pkg::load_func_e      rfunc,
  input  logic                     rreq_valid,
  output logic                     rreq_ready,
  output logic [`LSU_DATA_W-1:0]   rdata,
  output logic                     rres_valid,
  input  logic                     rres_ready,

  input  logic [`LSU_ADDR_W-1:0]   waddr,
  input  lsu_pkg::store_func_e     wfunc,
  input  logic [`LSU_DATA_W-1:0]   wdata,
  input  logic                     wreq_valid,
  output logic                     wreq_ready,
  output logic                     wres_valid,
  input  logic                     wres_ready
);

  decouple_if rreq_if ();
  decouple_if rres_if ();
  decouple_if wreq_if ();
  decouple_if wres_if ();

  // sram sits on mem_bus, lsu stores go out on wr_bus
  axi_if mem_bus ();
  axi_if wr_bus ();

  assign rreq_if.valid = rreq_valid;
  assign rreq_ready    = rreq_if.ready;
  assign rres_valid    = rres_if.valid;
  assign rres_if.ready = rres_ready;
  assign wreq_if.valid = wreq_valid;
  assign wreq_ready    = wreq_if.ready;
  assign wres_valid    = wres_if.valid;
  assign wres_if.ready = wres_ready;

  // store channel joins the shared slave port
  assign mem_bus.awvalid = wr_bus.awvalid;
  assign mem_bus.awaddr  = wr_bus.awaddr;
  assign mem_bus.awsize  = wr_bus.awsize;
  assign mem_bus.wvalid  = wr_bus.wvalid;
  assign mem_bus.wdata   = wr_bus.wdata;
  assign mem_bus.wstrb   = wr_bus.wstrb;
  assign mem_bus.bready  = wr_bus.bready;
  assign wr_bus.awready  = mem_bus.awready;
  assign wr_bus.wready   = mem_bus.wready;
  assign wr_bus.bvalid   = mem_bus.bvalid;

  lsu u_lsu (
    .clk   (clk),
    .rstn  (rstn),
    .raddr (raddr),
    .rfunc (rfunc),
    .rreq  (rreq_if.in),
    .rdata (rdata),
    .rres  (rres_if.out),
    .waddr (waddr),
    .wfunc (wfunc),
    .wdata (wdata),
    .wreq  (wreq_if.in),
    .wres  (wres_if.out),
    .ram_r (mem_bus.master),
    .ram_w (wr_bus.master)
  );

  axi_sram u_sram (
    .clk  (clk),
    .rstn (rstn),
    .bus  (mem_bus.slave)
  );

endmodule

// File: src/axi_sram.sv
`timescale 1ns/1ps

`include "lsu_params.svh"

module axi_sram (
  input  logic    clk,
  input  logic    rstn,
  axi_if.slave    bus
);

  import lsu_pkg::*;

  localparam int STRB_W = `LSU_BUS_W / 8;
  localparam int OFF_W  = $clog2(STRB_W);
  localparam int IDX_W  = $clog2(`LSU_MEM_WORDS);

  logic [`LSU_BUS_W-1:0] mem [`LSU_MEM_WORDS];

  // readies stay low for the first cycle out of reset
  logic init_done;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      init_done <= 1'b0;
    end else begin
      init_done <= 1'b1;
    end
  end

  // read channel
  chan_state_e            rd_state;
  logic [`LSU_BUS_W-1:0]  rdata_q;
  logic                   ar_hs;

  assign bus.arready = init_done && (rd_state == CH_IDLE);
  assign ar_hs       = bus.arvalid && bus.arready;
  assign bus.rvalid  = (rd_state == CH_RESP);
  assign bus.rdata   = rdata_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_state <= CH_IDLE;
    end else if (ar_hs) begin
      rd_state <= CH_RESP;
    end else if (bus.rvalid && bus.rready) begin
      rd_state <= CH_IDLE;
    end
  end

  // write channel
  chan_state_e            wr_state;
  logic                   aw_got;
  logic                   w_got;
  logic [`LSU_ADDR_W-1:0] aw_addr_q;
  logic [2:0]             aw_size_q;
  logic [`LSU_BUS_W-1:0]  w_data_q;
  logic [STRB_W-1:0]      w_strb_q;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   wr_commit;
  logic [`LSU_ADDR_W-1:0] eff_addr;
  logic [2:0]             eff_size;
  logic [`LSU_BUS_W-1:0]  eff_data;
  logic [STRB_W-1:0]      eff_strb;

  assign bus.awready = init_done && (wr_state == CH_IDLE) && !aw_got;
  assign bus.wready  = init_done && (wr_state == CH_IDLE) && !w_got;
  assign aw_hs       = bus.awvalid && bus.awready;
  assign w_hs        = bus.wvalid && bus.wready;
  assign bus.bvalid  = (wr_state == CH_RESP);

  // take whichever half arrived earlier from the latches
  assign eff_addr = aw_got ? aw_addr_q : bus.awaddr;
  assign eff_size = aw_got ? aw_size_q : bus.awsize;
  assign eff_data = w_got ? w_data_q : bus.wdata;
  assign eff_strb = w_got ? w_strb_q : bus.wstrb;

  assign wr_commit = (wr_state == CH_IDLE) && (aw_got || aw_hs) && (w_got || w_hs);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_state <= CH_IDLE;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
    end else if (wr_commit) begin
      wr_state <= CH_RESP;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_got <= 1'b1;
      end
      if (w_hs) begin
        w_got <= 1'b1;
      end
      if (bus.bvalid && bus.bready) begin
        wr_state <= CH_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_addr_q <= bus.awaddr;
      aw_size_q <= bus.awsize;
    end
    if (w_hs) begin
      w_data_q <= bus.wdata;
      w_strb_q <= bus.wstrb;
    end
  end

  // storage, word index wraps with the depth
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= mem[bus.araddr[OFF_W +: IDX_W]];
    end
    if (wr_commit) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (eff_strb[i]) begin
          mem[eff_addr[OFF_W +: IDX_W]][8*i +: 8] <= eff_data[8*i +: 8];
        end
      end
    end
  end

  // strobe width has to match the size the master announced
  a_strb_size: assert property (@(posedge clk) disable iff (!rstn)
    wr_commit && (int'(eff_addr[OFF_W-1:0]) + (1 << eff_size) <= STRB_W)
    |-> $countones(eff_strb) == (1 << eff_size));

endmodule

// File: src/lsu.sv
`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu (
  input  logic                     clk,
  input  logic                     rstn,

  // load request and response
  input  logic [`LSU_ADDR_W-1:0]   raddr,
  input  lsu_pkg::load_func_e      rfunc,
  decouple_if.in                   rreq,
  output logic [`LSU_DATA_W-1:0]   rdata,
  decouple_if.out                  rres,

  // store request and response
  input  logic [`LSU_ADDR_W-1:0]   waddr,
  input  lsu_pkg::store_func_e     wfunc,
  input  logic [`LSU_DATA_W-1:0]   wdata,
  decouple_if.in                   wreq,
  decouple_if.out                  wres,

  // memory side
  axi_if.master                    ram_r,
  axi_if.master                    ram_w
);

  import lsu_pkg::*;

  localparam int STRB_W = `LSU_BUS_W / 8;
  localparam int OFF_W  = $clog2(STRB_W);

  // read path

  // offset and kind of the load in flight
  logic [OFF_W-1:0]        roff_q;
  load_func_e              rfunc_q;
  logic [`LSU_BUS_W-1:0]   rbeat_shifted;

  // request goes straight onto AR
  assign ram_r.arvalid = rreq.valid;
  assign ram_r.araddr  = raddr;
  assign rreq.ready    = ram_r.arready;

  always_comb begin
    case (rfunc)
      LD_BS, LD_BU: ram_r.arsize = 3'd0;
      LD_HS, LD_HU: ram_r.arsize = 3'd1;
      default:      ram_r.arsize = 3'd2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rreq.valid && rreq.ready) begin
      roff_q  <= raddr[OFF_W-1:0];
      rfunc_q <= rfunc;
    end
  end

  // bring the addressed byte down to bit 0
  assign rbeat_shifted = ram_r.rdata >> {roff_q, 3'b000};

  always_comb begin
    case (rfunc_q)
      LD_BS:   rdata = {{(`LSU_DATA_W-8){rbeat_shifted[7]}}, rbeat_shifted[7:0]};
      LD_BU:   rdata = {{(`LSU_DATA_W-8){1'b0}}, rbeat_shifted[7:0]};
      LD_HS:   rdata = {{(`LSU_DATA_W-16){rbeat_shifted[15]}}, rbeat_shifted[15:0]};
      LD_HU:   rdata = {{(`LSU_DATA_W-16){1'b0}}, rbeat_shifted[15:0]};
      // LD_W and unknown codes
      default: rdata = rbeat_shifted[`LSU_DATA_W-1:0];
    endcase
  end

  // error responses are not looked at
  assign rres.valid  = ram_r.rvalid;
  assign ram_r.rready = rres.ready;

  // write path

  logic [STRB_W-1:0]       wmask;
  logic                    aw_pend;
  logic                    w_pend;

  always_comb begin
    case (wfunc)
      ST_H:    ram_w.awsize = 3'd1;
      ST_W:    ram_w.awsize = 3'd2;
      default: ram_w.awsize = 3'd0;
    endcase
  end

  // unshifted strobe, byte lanes from bit 0
  always_comb begin
    case (wfunc)
      ST_H:    wmask = STRB_W'(2'b11);
      ST_W:    wmask = STRB_W'(4'b1111);
      default: wmask = STRB_W'(1'b1);
    endcase
  end

  // move data and strobe onto the addressed lanes
  assign ram_w.wdata = {{(`LSU_BUS_W-`LSU_DATA_W){1'b0}}, wdata} << {waddr[OFF_W-1:0], 3'b000};
  assign ram_w.wstrb = wmask << waddr[OFF_W-1:0];
  assign ram_w.awaddr = waddr;

  // address and data still owed to the bus for the current store
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else if (ram_w.bvalid && ram_w.bready) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else begin
      if (ram_w.awvalid && ram_w.awready) begin
        aw_pend <= 1'b0;
      end
      if (ram_w.wvalid && ram_w.wready) begin
        w_pend <= 1'b0;
      end
    end
  end

  assign ram_w.awvalid = wreq.valid && aw_pend;
  assign ram_w.wvalid  = wreq.valid && w_pend;

  // accepted once both halves are in, never again until the B beat
  assign wreq.ready = (ram_w.awready || !aw_pend) && (ram_w.wready || !w_pend) &&
                      (aw_pend || w_pend);

  assign wres.valid   = ram_w.bvalid;
  assign ram_w.bready = wres.ready;

  // held load result must not move while the core stalls
  a_rres_hold: assert property (@(posedge clk) disable iff (!rstn)
    rres.valid && !rres.ready |=> rres.valid && $stable(rdata));

  a_wstrb_nonzero: assert property (@(posedge clk) disable iff (!rstn)
    ram_w.wvalid |-> ram_w.wstrb != '0);

endmodule

// File: src/axi_if.sv
`timescale 1ns/1ps

`include "lsu_params.svh"

// single-beat axi-lite style bus, no ids, no bursts, no error response
interface axi_if;

  // read address and read data
  logic                      arvalid;
  logic                      arready;
  logic [`LSU_ADDR_W-1:0]    araddr;
  logic [2:0]                arsize;
  logic                      rvalid;
  logic                      rready;
  logic [`LSU_BUS_W-1:0]     rdata;

  // write address, write data and write response
  logic                      awvalid;
  logic                      awready;
  logic [`LSU_ADDR_W-1:0]    awaddr;
  logic [2:0]                awsize;
  logic                      wvalid;
  logic                      wready;
  logic [`LSU_BUS_W-1:0]     wdata;
  logic [`LSU_BUS_W/8-1:0]   wstrb;
  logic                      bvalid;
  logic                      bready;

  modport master (
    output arvalid, araddr, arsize, rready,
    input  arready, rvalid, rdata,
    output awvalid, awaddr, awsize, wvalid, wdata, wstrb, bready,
    input  awready, wready, bvalid
  );

  modport slave (
    input  arvalid, araddr, arsize, rready,
    output arready, rvalid, rdata,
    input  awvalid, awaddr, awsize, wvalid, wdata, wstrb, bready,
    output awready, wready, bvalid
  );

endinterface

// File: src/decouple_if.sv
`timescale 1ns/1ps

// plain valid/ready handshake, payload travels beside it
interface decouple_if;

  logic valid;
  logic ready;

  // receiving side
  modport in (input valid, output ready);

  // sending side
  modport out (output valid, input ready);

endinterface

// File: src/lsu_pkg.sv
package lsu_pkg;

  // load kinds, funct3 encoding of the base ISA
  typedef enum logic [2:0] {
    LD_BS = 3'b000,
    LD_HS = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } load_func_e;

  // store kinds, unknown codes behave as a byte store
  typedef enum logic [2:0] {
    ST_B = 3'b000,
    ST_H = 3'b001,
    ST_W = 3'b010
  } store_func_e;

  // per-channel state of the sram slave
  typedef enum logic {
    CH_IDLE = 1'b0,
    CH_RESP = 1'b1
  } chan_state_e;

endpackage

// File: src/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// byte address width seen by the core
`define LSU_ADDR_W 32

// core register width
`define LSU_DATA_W 32

// one beat on the memory bus
`define LSU_BUS_W 64

// sram depth in bus words, addresses wrap beyond this
`define LSU_MEM_WORDS 256

`endif
